// ==== rv_alu.sv ====
// Integer ALU plus the branch comparator
// Both see the same two operands
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    input  rv_core_pkg::alu_op_e alu_op,
    input  logic [2:0]           funct3,
    output logic [`RV_XLEN-1:0]  result,
    output logic                 branch_taken
);
    import rv_core_pkg::*;

    localparam int SH_W = $clog2(`RV_XLEN);

    logic [SH_W-1:0] shamt;
    logic            lt_s;
    logic            lt_u;

    assign shamt = b[SH_W-1:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            default:  result = a & b;
        endcase
    end

    // BEQ BNE BLT BGE BLTU BGEU
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (a == b);
            3'b001:  branch_taken = (a != b);
            3'b100:  branch_taken = lt_s;
            3'b101:  branch_taken = !lt_s;
            3'b110:  branch_taken = lt_u;
            3'b111:  branch_taken = !lt_u;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== rv_core.sv ====
// Top of the RV32I front end: fetch, skid buffer, execute
// Memory port and retirement trace go to the outside
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  hold,
    output logic                  imem_req,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic                  imem_ready,
    input  logic [`RV_XLEN-1:0]   imem_rdata,
    output logic                  retire_valid,
    output logic [`RV_XLEN-1:0]   retire_pc,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]   retire_data,
    output logic                  halt
);
    import rv_core_pkg::*;

    // Fetch to buffer
    logic                push;
    logic [`RV_XLEN-1:0] push_pc;
    inst_t               push_inst;
    logic                full;

    // Buffer to execute
    logic                empty;
    logic [`RV_XLEN-1:0] head_pc;
    inst_t               head_inst;
    logic                pop;

    // Execute back to fetch and buffer
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    rv_fetch_unit fetch_unit_inst (
        .clk(clk), .rstn(rstn),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_rdata(imem_rdata),
        .full(full), .redirect(redirect), .redirect_pc(redirect_pc),
        .push(push), .push_pc(push_pc), .push_inst(push_inst)
    );

    rv_fetch_buffer fetch_buffer_inst (
        .clk(clk), .rstn(rstn),
        .push(push), .push_pc(push_pc), .push_inst(push_inst),
        .pop(pop), .flush(redirect),
        .full(full), .empty(empty), .head_pc(head_pc), .head_inst(head_inst)
    );

    rv_execute execute_inst (
        .clk(clk), .rstn(rstn), .hold(hold),
        .empty(empty), .head_pc(head_pc), .head_inst(head_inst),
        .pop(pop), .redirect(redirect), .redirect_pc(redirect_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data), .halt(halt)
    );

endmodule

// ==== rv_core_params.svh ====
// Global sizes and reset values for the RV32I front end
// Include wherever a width or the reset PC is needed
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data and address width
`define RV_XLEN       32

// Register file geometry
`define RV_REG_COUNT  32
`define RV_REG_AW     5

// Fetch skid buffer entries
`define RV_BUF_DEPTH  2

// First fetch address and PC step
`define RV_PC_RESET   32'h0000_0000
`define RV_INST_BYTES 4

`endif

// ==== rv_core_pkg.sv ====
// Shared types of the core: instruction word views and encodings
// Modules import this inside their body
`include "rv_core_params.svh"

package rv_core_pkg;

    // ####################
    // Instruction views
    // ####################

    // Register-register layout
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    // Immediate layout, also used for SYSTEM
    typedef struct packed {
        logic [11:0]           imm12;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    // Upper immediate layout
    typedef struct packed {
        logic [19:0]           imm20;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } inst_u_t;

    // Branch and jump, bits still scrambled
    typedef struct packed {
        logic [24:0] raw;
        logic [6:0]  opcode;
    } inst_bj_t;

    // One fetched word, decoded several ways
    typedef union packed {
        inst_r_t  r;
        inst_i_t  i;
        inst_u_t  u;
        inst_bj_t bj;
    } inst_t;

    // ####################
    // Encodings
    // ####################

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

endpackage

// ==== rv_decoder.sv ====
// Combinational RV32I decode for the kept instruction classes
// Gives register indices, the immediate, ALU operation and class flags
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_decoder (
    input  rv_core_pkg::inst_t    inst,
    output logic [`RV_REG_AW-1:0] rs1,
    output logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_REG_AW-1:0] rd,
    output logic [`RV_XLEN-1:0]   imm,
    output rv_core_pkg::alu_op_e  alu_op,
    output logic                  is_op,
    output logic                  is_op_imm,
    output logic                  is_lui,
    output logic                  is_jal,
    output logic                  is_branch,
    output logic                  is_system,
    output logic [2:0]            funct3
);
    import rv_core_pkg::*;

    logic is_shift;

    assign rs1    = inst.r.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;
    assign funct3 = inst.r.funct3;

    assign is_op     = (inst.r.opcode == OPC_OP);
    assign is_op_imm = (inst.r.opcode == OPC_OP_IMM);
    assign is_lui    = (inst.r.opcode == OPC_LUI);
    assign is_jal    = (inst.r.opcode == OPC_JAL);
    assign is_branch = (inst.r.opcode == OPC_BRANCH);
    // ECALL has imm12 0, EBREAK has 1
    assign is_system = (inst.r.opcode == OPC_SYSTEM) && (inst.i.funct3 == 3'b000)
                       && (inst.i.imm12[11:1] == '0);

    assign is_shift  = (inst.i.funct3 == 3'b001) || (inst.i.funct3 == 3'b101);

    // Immediate format follows the class
    always_comb begin
        imm = '0;
        if (is_op_imm && is_shift) begin
            // Only the shift amount field counts
            imm = {27'b0, inst.i.imm12[4:0]};
        end else if (is_op_imm) begin
            imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
        end else if (is_lui) begin
            imm = {inst.u.imm20, 12'b0};
        end else if (is_branch) begin
            imm = {{20{inst.bj.raw[24]}}, inst.bj.raw[0], inst.bj.raw[23:18],
                   inst.bj.raw[4:1], 1'b0};
        end else if (is_jal) begin
            imm = {{12{inst.bj.raw[24]}}, inst.bj.raw[12:5], inst.bj.raw[13],
                   inst.bj.raw[23:14], 1'b0};
        end
    end

    // funct3 picks the operation, bit 30 splits ADD/SUB and SRL/SRA
    always_comb begin
        case (inst.r.funct3)
            3'b000:  alu_op = (is_op && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

endmodule

// ==== rv_execute.sv ====
// Single-cycle execute: decode, operand read, ALU, writeback, redirect
// Retirement and halt are reported one cycle after the pop
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  hold,
    input  logic                  empty,
    input  logic [`RV_XLEN-1:0]   head_pc,
    input  rv_core_pkg::inst_t    head_inst,
    output logic                  pop,
    output logic                  redirect,
    output logic [`RV_XLEN-1:0]   redirect_pc,
    output logic                  retire_valid,
    output logic [`RV_XLEN-1:0]   retire_pc,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]   retire_data,
    output logic                  halt
);
    import rv_core_pkg::*;

    logic [`RV_REG_AW-1:0] rs1, rs2, rd;
    logic [`RV_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    logic                  is_op, is_op_imm, is_lui, is_jal, is_branch, is_system;
    logic [2:0]            funct3;

    logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   alu_result;
    logic                  branch_taken;
    logic [`RV_XLEN-1:0]   result;
    logic                  writes_rd;

    rv_decoder decoder_inst (
        .inst(head_inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
        .is_op(is_op), .is_op_imm(is_op_imm), .is_lui(is_lui), .is_jal(is_jal),
        .is_branch(is_branch), .is_system(is_system), .funct3(funct3)
    );

    rv_reg_file reg_file_inst (
        .clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .rd(rd), .wdata(result),
        .wen(pop && writes_rd), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    // Immediate for OP-IMM, register otherwise
    assign op_b = is_op_imm ? imm : rs2_data;

    rv_alu alu_inst (
        .a(rs1_data), .b(op_b), .alu_op(alu_op), .funct3(funct3),
        .result(alu_result), .branch_taken(branch_taken)
    );

    // Take the head whenever it is there and nothing stops us
    assign pop = !empty && !hold && !halt;

    assign writes_rd = is_op || is_op_imm || is_lui || is_jal;
    assign result    = is_lui ? imm :
                       is_jal ? head_pc + `RV_INST_BYTES : alu_result;

    // Control transfer resolved in the pop cycle
    assign redirect    = pop && (is_jal || (is_branch && branch_taken));
    assign redirect_pc = head_pc + imm;

    // ####################
    // Retirement report
    // ####################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            retire_valid <= 1'b0;
            halt         <= 1'b0;
        end else begin
            retire_valid <= pop && !is_system;
            // Sticky until reset
            if (pop && is_system) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire_pc   <= head_pc;
            retire_rd   <= writes_rd ? rd : '0;
            // Nothing visible for x0 or non-writing instructions
            retire_data <= (writes_rd && (rd != '0)) ? result : '0;
        end
    end

    // After halt nothing is consumed and nothing more retires
    a_halt_quiet: assert property (@(posedge clk) disable iff (!rstn)
        halt |-> !pop ##1 !retire_valid);

endmodule

// ==== rv_fetch_buffer.sv ====
// Small circular skid buffer between fetch and execute
// Holds PC/instruction pairs; flush drops everything at once
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_fetch_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               push,
    input  logic [`RV_XLEN-1:0] push_pc,
    input  rv_core_pkg::inst_t push_inst,
    input  logic               pop,
    input  logic               flush,
    output logic               full,
    output logic               empty,
    output logic [`RV_XLEN-1:0] head_pc,
    output rv_core_pkg::inst_t head_inst
);
    import rv_core_pkg::*;

    localparam int PTR_W = $clog2(`RV_BUF_DEPTH);
    localparam int CNT_W = $clog2(`RV_BUF_DEPTH + 1);

    // Entry storage
    logic [`RV_XLEN-1:0] pc_mem   [`RV_BUF_DEPTH];
    inst_t               inst_mem [`RV_BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Pointers, count
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`RV_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`RV_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
    end

    assign full      = (count == CNT_W'(`RV_BUF_DEPTH));
    assign empty     = (count == '0);
    assign head_pc   = pc_mem[rd_ptr];
    assign head_inst = inst_mem[rd_ptr];

    // Fetch must hold off while full
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full);

endmodule

// ==== rv_fetch_unit.sv ====
// Instruction fetch over a request-level / ready-pulse memory port
// Pushes each returned word with its PC into the fetch buffer
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_fetch_unit (
    input  logic               clk,
    input  logic               rstn,
    output logic               imem_req,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic               imem_ready,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    input  logic               full,
    input  logic               redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic               push,
    output logic [`RV_XLEN-1:0] push_pc,
    output rv_core_pkg::inst_t push_inst
);
    import rv_core_pkg::*;

    // Next address to fetch
    logic [`RV_XLEN-1:0] pc;
    // Address of the outstanding request
    logic [`RV_XLEN-1:0] addr_q;
    logic                busy;
    // Outstanding word belongs to a dead path
    logic                discard;

    logic                start;

    // New request only once the last one has completed and there is room
    assign start = !busy && !full;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc      <= `RV_PC_RESET;
            addr_q  <= `RV_PC_RESET;
            busy    <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (start) begin
                busy   <= 1'b1;
                // Redirect in this cycle goes straight out as the address
                addr_q <= redirect ? redirect_pc : pc;
            end else if (busy && imem_ready) begin
                busy    <= 1'b0;
                discard <= 1'b0;
            end else if (busy && redirect) begin
                // Let the old access finish, drop its word
                discard <= 1'b1;
            end

            if (redirect) begin
                pc <= redirect_pc;
            end else if (busy && imem_ready && !discard) begin
                pc <= pc + `RV_INST_BYTES;
            end
        end
    end

    assign imem_req  = busy;
    assign imem_addr = addr_q;

    // Word passes through to the buffer in the ready cycle
    assign push      = busy && imem_ready && !discard;
    assign push_pc   = addr_q;
    assign push_inst = inst_t'(imem_rdata);

    // Memory sees one steady address for the whole access
    a_addr_stable: assert property (@(posedge clk) disable iff (!rstn)
        imem_req && !imem_ready |=> imem_req && $stable(imem_addr));

endmodule

// ==== rv_reg_file.sv ====
// Integer register file, two read ports and one write port
// x0 has no storage and always reads zero
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_reg_file (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    input  logic [`RV_REG_AW-1:0] rd,
    input  logic [`RV_XLEN-1:0]   wdata,
    input  logic                  wen,
    output logic [`RV_XLEN-1:0]   rs1_data,
    output logic [`RV_XLEN-1:0]   rs2_data
);
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int k = 1; k < `RV_REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Combinational reads
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== sim.f ====
+incdir+.
rv_core_pkg.sv
rv_fetch_unit.sv
rv_fetch_buffer.sv
rv_decoder.sv
rv_alu.sv
rv_reg_file.sv
rv_execute.sv
rv_core.sv
tb_imem_model.sv
tb_rv_core.sv

// ==== tb_imem_model.sv ====
// Instruction memory model for the core testbench
// Answers each request after 1 to 4 cycles; the testbench loads mem directly
`timescale 1ns/1ns
`include "rv_core_params.svh"

module tb_imem_model #(
    parameter int WORDS = 1024
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req,
    input  logic [`RV_XLEN-1:0] addr,
    output logic                ready,
    output logic [`RV_XLEN-1:0] rdata
);
    localparam int IDX_W = $clog2(WORDS);

    // Program storage, word addressed
    logic [`RV_XLEN-1:0] mem [WORDS];
    logic                pending;
    int                  wait_cnt;
    integer              seed;

    initial begin
        seed     = 69971;
        ready    = 1'b0;
        rdata    = '0;
        pending  = 1'b0;
        wait_cnt = 0;
    end

    // Outputs move on the falling edge, the core samples on the rising one
    always @(negedge clk) begin
        if (!rstn) begin
            ready   <= 1'b0;
            pending <= 1'b0;
        end else if (ready) begin
            // One-cycle pulse, core drops req at the same rising edge
            ready <= 1'b0;
        end else if (req && !pending) begin
            pending  <= 1'b1;
            wait_cnt <= 1 + ($unsigned($random(seed)) % 4);
        end else if (pending) begin
            if (wait_cnt == 1) begin
                ready   <= 1'b1;
                rdata   <= mem[addr[IDX_W+1:2]];
                pending <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// ==== tb_rv_core.sv ====
// Testbench for the core: random program, ISA reference model, retirement checks
// Program and expected retirement trace are built at time zero, then the core runs to ECALL
`timescale 1ns/1ns
`include "rv_core_params.svh"

module tb_rv_core;
    localparam int MEM_WORDS = 1024;
    localparam int MAX_RET   = 512;
    localparam int ALU_COUNT = 150;

    logic                  clk;
    logic                  rstn;
    logic                  hold;
    logic                  imem_req;
    logic                  imem_ready;
    logic [`RV_XLEN-1:0]   imem_addr;
    logic [`RV_XLEN-1:0]   imem_rdata;
    logic                  retire_valid;
    logic                  halt;
    logic [`RV_XLEN-1:0]   retire_pc;
    logic [`RV_XLEN-1:0]   retire_data;
    logic [`RV_REG_AW-1:0] retire_rd;

    // Reference model state and expected retirement trace
    logic [`RV_XLEN-1:0]   model_regs [`RV_REG_COUNT];
    logic [`RV_XLEN-1:0]   exp_pc     [MAX_RET];
    logic [`RV_REG_AW-1:0] exp_rd     [MAX_RET];
    logic [`RV_XLEN-1:0]   exp_data   [MAX_RET];
    int                    exp_count;
    int                    retire_cnt;
    int                    prog_len = 0;
    int                    widx;
    integer                seed = 69971;

    rv_core rv_core_inst (
        .clk(clk), .rstn(rstn), .hold(hold),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_rdata(imem_rdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data), .halt(halt)
    );

    tb_imem_model #(.WORDS(MEM_WORDS)) imem_inst (
        .clk(clk), .rstn(rstn), .req(imem_req), .addr(imem_addr),
        .ready(imem_ready), .rdata(imem_rdata)
    );

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic stop_on_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        stop_on_error($sformatf("Fail %s got %h expected %h", name, got, expected));
    endtask

    function automatic int pick(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // ####################
    // ISA rules
    // ####################

    // funct3 selects the operation and alt is instruction bit 30
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt,
                                            logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ####################
    // Program generation
    // ####################

    // Log one retirement at the current word and step the model
    task automatic expect_retire(logic [4:0] rd, logic [31:0] data);
        exp_pc[exp_count]   = widx * `RV_INST_BYTES;
        exp_rd[exp_count]   = rd;
        exp_data[exp_count] = (rd == 5'd0) ? '0 : data;
        if (rd != 5'd0) begin
            model_regs[rd] = data;
        end
        exp_count++;
        widx++;
    endtask

    // Fill jumped-over words with writes to nonzero registers that must never run
    task automatic skip_words(int n);
        logic [31:0] junk;
        repeat (n) begin
            junk = $random(seed);
            imem_inst.mem[widx] = {junk[31:12], junk[11:7] | 5'd1, 7'b0010011};
            widx++;
        end
    endtask

    task automatic add_alu_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [31:0] b;
        int          sel;
        rd  = (pick(8) == 0) ? 5'd0 : 5'(pick(32));
        rs1 = 5'(pick(32));
        rs2 = 5'(pick(32));
        f3  = 3'(pick(8));
        alt = (pick(2) == 1) && (f3 == 3'd0 || f3 == 3'd5);
        sel = pick(8);
        if (sel < 4) begin
            imem_inst.mem[widx] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            expect_retire(rd, alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]));
        end else if (sel < 7) begin
            // Only SRAI keeps bit 30 among the immediate forms
            alt   = alt && (f3 == 3'd5);
            imm12 = 12'(pick(4096));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
                b     = {27'b0, imm12[4:0]};
            end else begin
                b = {{20{imm12[11]}}, imm12};
            end
            imem_inst.mem[widx] = {imm12, rs1, f3, rd, 7'b0010011};
            expect_retire(rd, alu_ref(f3, alt, model_regs[rs1], b));
        end else begin
            b = $random(seed);
            imem_inst.mem[widx] = {b[31:12], rd, 7'b0110111};
            expect_retire(rd, {b[31:12], 12'b0});
        end
    endtask

    task automatic add_branch();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [12:0] off;
        logic        taken;
        int          skip;
        rs1 = 5'(pick(32));
        rs2 = (pick(4) == 0) ? rs1 : 5'(pick(32));
        // 0..5 mapped onto BEQ BNE BLT BGE BLTU BGEU
        f3 = 3'(pick(6));
        if (f3 >= 3'd2) begin
            f3 = f3 + 3'd2;
        end
        skip  = pick(5);
        off   = 13'((skip + 1) * `RV_INST_BYTES);
        taken = branch_ref(f3, model_regs[rs1], model_regs[rs2]);
        imem_inst.mem[widx] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
                               7'b1100011};
        expect_retire(5'd0, '0);
        if (taken) begin
            skip_words(skip);
        end
    endtask

    task automatic add_jal();
        logic [4:0]  rd;
        logic [20:0] off;
        logic [31:0] link;
        int          skip;
        rd   = 5'(pick(32));
        skip = pick(5);
        off  = 21'((skip + 1) * `RV_INST_BYTES);
        link = (widx + 1) * `RV_INST_BYTES;
        imem_inst.mem[widx] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        expect_retire(rd, link);
        skip_words(skip);
    endtask

    task automatic build_program();
        int alu_done;
        int kind;
        alu_done  = 0;
        widx      = 0;
        exp_count = 0;
        for (int k = 0; k < `RV_REG_COUNT; k++) begin
            model_regs[k] = '0;
        end
        // Unused words hold their own index under the custom-0 opcode
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem_inst.mem[k] = {k[24:0], 7'b0001011};
        end
        while (alu_done < ALU_COUNT) begin
            kind = pick(10);
            if (kind < 7) begin
                add_alu_inst();
                alu_done++;
            end else if (kind < 9) begin
                add_branch();
            end else begin
                add_jal();
            end
        end
        // ECALL closes the program
        imem_inst.mem[widx] = 32'h0000_0073;
        prog_len = widx + 1;
    endtask

    // ####################
    // Clock, reset, hold
    // ####################

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        build_program();
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        wait (halt === 1'b1);
        repeat (4) @(negedge clk);
        if (retire_cnt == exp_count) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_on_mismatch("retire_count", retire_cnt, exp_count);
        end
    end

    // Random stall bursts on the falling edge
    initial begin
        int gap;
        int burst;
        hold = 1'b0;
        wait (rstn === 1'b1);
        while (halt !== 1'b1) begin
            gap = 1 + pick(8);
            repeat (gap) @(negedge clk);
            hold = 1'b1;
            burst = 1 + pick(5);
            repeat (burst) @(negedge clk);
            hold = 1'b0;
        end
    end

    // Watchdog sized from the program length
    initial begin
        wait (prog_len > 0);
        #(prog_len * 40 * 8);
        stop_on_error("Timeout: the core never halted on the final ECALL");
    end

    always @(posedge clk) begin
        if (!rstn) begin
            retire_cnt <= 0;
        end else if (retire_valid) begin
            retire_cnt <= retire_cnt + 1;
        end
    end

    // ####################
    // Memory port checks
    // ####################

    // Request level and address stay put until the ready pulse
    a_imem_steady: assert property (@(posedge clk) disable iff (!rstn)
        imem_req && !imem_ready |=> imem_req && $stable(imem_addr))
        else stop_on_error("The memory request dropped or changed address before imem_ready");

    // Next request starts one cycle after ready at the earliest
    a_imem_gap: assert property (@(posedge clk) disable iff (!rstn)
        imem_ready |=> !imem_req)
        else stop_on_error("A new memory request started right at the imem_ready edge");

    // ####################
    // Retirement checks
    // ####################

    a_ret_pc: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> retire_pc == exp_pc[retire_cnt])
        else stop_on_mismatch("retire_pc", $sampled(retire_pc), exp_pc[$sampled(retire_cnt)]);

    a_ret_rd: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> retire_rd == exp_rd[retire_cnt])
        else stop_on_mismatch("retire_rd", $sampled(retire_rd), exp_rd[$sampled(retire_cnt)]);

    a_ret_data: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> retire_data == exp_data[retire_cnt])
        else stop_on_mismatch("retire_data", $sampled(retire_data),
                              exp_data[$sampled(retire_cnt)]);

    a_ret_extra: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> retire_cnt < exp_count)
        else stop_on_error("An instruction retired after the whole program had retired");

    // Stalled cycle pops nothing, so nothing retires one cycle later
    a_hold_stall: assert property (@(posedge clk) disable iff (!rstn)
        hold |=> !retire_valid)
        else stop_on_mismatch("retire_valid", 1, 0);

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rstn)
        halt |-> !retire_valid)
        else stop_on_mismatch("retire_valid", 1, 0);

    a_halt_count: assert property (@(posedge clk) disable iff (!rstn)
        $rose(halt) |-> retire_cnt == exp_count)
        else stop_on_mismatch("retire_count", $sampled(retire_cnt), exp_count);

endmodule
